//--- Bender.yml
package:
  name: vec_unit

sources:
  - source/vec_cfg_pkg.sv
  - source/vec_types_pkg.sv
  - source/vec_rf_if.sv
  - source/vec_csr.sv
  - source/vec_group_counter.sv
  - source/vec_sequencer.sv
  - source/vec_regbank.sv
  - source/vec_alu.sv
  - source/vec_unit_top.sv
  - target: simulation
    files:
      - bench/tb_vec_unit.sv

//--- bench/tb_vec_unit.sv
module tb_vec_unit;

    import vec_cfg_pkg::*;
    import vec_types_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int ROW_CYCLES = 12;

    // One instruction with its expected scalar side response
    typedef struct {
        vec_op_e     op;
        logic [31:0] instr;
        logic [31:0] scalar;
        logic [31:0] exp_res;
        logic        exp_wen;
        logic        chk;
        int          hold_cycles;
    } row_t;

    row_t rows[$];
    logic table_ready;

    logic            clk;
    logic            reset_n;
    logic [31:0]     instruction_i;
    vec_op_e         vector_operation_i;
    logic [XLEN-1:0] op1_scalar_i;
    logic            hold_o;
    logic [XLEN-1:0] vtype_o;
    logic [XLEN-1:0] res_scalar_o;
    logic            wr_en_scalar_o;

    vec_unit_top u_dut (
        .clk                (clk),
        .reset_n            (reset_n),
        .instruction_i      (instruction_i),
        .vector_operation_i (vector_operation_i),
        .op1_scalar_i       (op1_scalar_i),
        .hold_o             (hold_o),
        .vtype_o            (vtype_o),
        .res_scalar_o       (res_scalar_o),
        .wr_en_scalar_o     (wr_en_scalar_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoding and table building
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] vsetvli_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [10:0] zimm);
        return {1'b0, zimm, rs1, 3'b111, rd, 7'h57};
    endfunction

    function automatic logic [31:0] arith_word(input op_cat_e cat, input logic [4:0] vd,
                                               input logic [4:0] rs1, input logic [4:0] vs2);
        return {6'b000000, 1'b1, vs2, rs1, cat, vd, 7'h57};
    endfunction

    function automatic logic [31:0] vmv_word(input logic [4:0] rd, input logic [4:0] vs2);
        return {6'b010000, 1'b1, vs2, 5'd0, 3'b010, rd, 7'h57};
    endfunction

    task automatic add_row(input vec_op_e op, input logic [31:0] instr,
                           input logic [31:0] scalar, input logic [31:0] exp_res,
                           input logic exp_wen, input logic chk, input int hold_cycles);
        row_t r;
        r = '{op, instr, scalar, exp_res, exp_wen, chk, hold_cycles};
        rows.push_back(r);
    endtask

    task automatic set_vl(input logic [4:0] rd, input logic [4:0] rs1, input logic [10:0] zimm,
                          input logic [31:0] avl, input logic [31:0] exp_vl);
        add_row(VSETVLI, vsetvli_word(rd, rs1, zimm), avl, exp_vl, 1'b1, 1'b1, 0);
    endtask

    // Hold covers the issue cycle plus one cycle per group register
    task automatic arith_op(input vec_op_e op, input op_cat_e cat, input logic [4:0] vd,
                            input logic [4:0] vs2, input logic [4:0] rs1,
                            input logic [31:0] scalar, input int lmul);
        add_row(op, arith_word(cat, vd, rs1, vs2), scalar, 32'h0, 1'b0, 1'b1, lmul + 1);
    endtask

    task automatic move_to_scalar(input logic [4:0] vs2, input logic [31:0] expected);
        add_row(VMV_X_S, vmv_word(5'd5, vs2), $urandom(), expected, 1'b1, 1'b1, 0);
    endtask

    task automatic build_table();
        // AVL below and above VLMAX at e8 m1
        set_vl(5'd1, 5'd2, 11'h000, 32'd5, 32'd5);
        set_vl(5'd1, 5'd2, 11'h000, 32'd100, 32'd8);
        add_row(VNOP, 32'h0, $urandom(), 32'h0, 1'b0, 1'b0, 0);
        // SEW 8 add and sub wrap per byte
        arith_op(VADD, OPIVX, 5'd1, 5'd0, 5'd3, 32'h0000_00F0, 1);
        arith_op(VADD, OPIVX, 5'd1, 5'd1, 5'd3, 32'h0000_0020, 1);
        move_to_scalar(5'd1, 32'h0000_0010);
        arith_op(VSUB, OPIVI, 5'd2, 5'd1, 5'h1D, $urandom(), 1);
        move_to_scalar(5'd2, 32'h0000_0013);
        arith_op(VSUB, OPIVX, 5'd3, 5'd0, 5'd3, 32'h0000_0001, 1);
        move_to_scalar(5'd3, 32'hFFFF_FFFF);
        // SEW 16 where rs1 zero with rd nonzero gives VLMAX
        set_vl(5'd1, 5'd0, 11'h008, $urandom(), 32'd4);
        arith_op(VADD, OPIVX, 5'd4, 5'd3, 5'd3, 32'h0000_0002, 1);
        move_to_scalar(5'd4, 32'h0000_0001);
        arith_op(VADD, OPIVI, 5'd5, 5'd3, 5'h0F, $urandom(), 1);
        move_to_scalar(5'd5, 32'h0000_000E);
        // SEW 32
        set_vl(5'd1, 5'd2, 11'h010, 32'd3, 32'd2);
        arith_op(VADD, OPIVX, 5'd6, 5'd3, 5'd3, 32'h0000_0010, 1);
        move_to_scalar(5'd6, 32'h0000_000F);
        arith_op(VSUB, OPIVI, 5'd7, 5'd6, 5'h10, $urandom(), 1);
        move_to_scalar(5'd7, 32'h0000_001F);
        // Vector-vector logic, min, max and shifts on A5 and 3C bytes
        set_vl(5'd1, 5'd2, 11'h000, 32'd8, 32'd8);
        arith_op(VADD, OPIVX, 5'd8, 5'd0, 5'd3, 32'h0000_00A5, 1);
        arith_op(VADD, OPIVX, 5'd9, 5'd0, 5'd3, 32'h0000_003C, 1);
        arith_op(VAND, OPIVV, 5'd10, 5'd8, 5'd9, $urandom(), 1);
        move_to_scalar(5'd10, 32'h0000_0024);
        arith_op(VOR, OPIVV, 5'd10, 5'd8, 5'd9, $urandom(), 1);
        move_to_scalar(5'd10, 32'hFFFF_FFBD);
        arith_op(VXOR, OPIVV, 5'd10, 5'd8, 5'd9, $urandom(), 1);
        move_to_scalar(5'd10, 32'hFFFF_FF99);
        arith_op(VMINU, OPIVV, 5'd10, 5'd8, 5'd9, $urandom(), 1);
        move_to_scalar(5'd10, 32'h0000_003C);
        arith_op(VMAXU, OPIVV, 5'd10, 5'd8, 5'd9, $urandom(), 1);
        move_to_scalar(5'd10, 32'hFFFF_FFA5);
        // Shift amount 0x3C is 4 modulo 8
        arith_op(VSLL, OPIVV, 5'd10, 5'd8, 5'd9, $urandom(), 1);
        move_to_scalar(5'd10, 32'h0000_0050);
        arith_op(VSRL, OPIVV, 5'd10, 5'd8, 5'd9, $urandom(), 1);
        move_to_scalar(5'd10, 32'h0000_000A);
        arith_op(VSRA, OPIVV, 5'd10, 5'd8, 5'd9, $urandom(), 1);
        move_to_scalar(5'd10, 32'hFFFF_FFFA);
        // LMUL 4 group where v8..v11 hold A5, 3C, FA and 00
        set_vl(5'd1, 5'd0, 11'h002, $urandom(), 32'd32);
        arith_op(VADD, OPIVX, 5'd16, 5'd8, 5'd3, 32'h0000_0011, 4);
        move_to_scalar(5'd16, 32'hFFFF_FFB6);
        move_to_scalar(5'd17, 32'h0000_004D);
        move_to_scalar(5'd18, 32'h0000_000B);
        move_to_scalar(5'd19, 32'h0000_0011);
        // Both rs1 and rd zero keep the old vl even though VLMAX drops to 16
        set_vl(5'd0, 5'd0, 11'h001, $urandom(), 32'd32);
        // vl 0 writes nothing
        set_vl(5'd1, 5'd2, 11'h000, 32'd0, 32'd0);
        arith_op(VADD, OPIVX, 5'd16, 5'd0, 5'd3, 32'h0000_0055, 1);
        move_to_scalar(5'd16, 32'hFFFF_FFB6);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checking and run control
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got %h, expected %h", name, actual, expected);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    initial begin
        logic [31:0] exp_vtype;
        int          cycles;
        clk                = 1'b0;
        reset_n            = 1'b0;
        instruction_i      = 32'h0;
        vector_operation_i = VNOP;
        op1_scalar_i       = '0;
        table_ready        = 1'b0;
        exp_vtype          = 32'h0;
        void'($urandom(32'h463c6f13));
        build_table();
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        #2;
        reset_n = 1'b1;

        foreach (rows[i]) begin
            instruction_i      = rows[i].instr;
            vector_operation_i = rows[i].op;
            op1_scalar_i       = rows[i].scalar;
            cycles             = 0;
            // Count hold cycles until the unit lets the issuer go
            @(negedge clk);
            while (hold_o) begin
                cycles++;
                @(negedge clk);
            end
            check_value("hold_o cycles", cycles, rows[i].hold_cycles);
            check_value("vtype_o", vtype_o, exp_vtype);
            if (rows[i].chk) begin
                check_value("res_scalar_o", res_scalar_o, rows[i].exp_res);
                check_value("wr_en_scalar_o", 32'(wr_en_scalar_o), 32'(rows[i].exp_wen));
            end
            // vtype shows the new setting from the next edge on
            if (rows[i].op == VSETVLI) begin
                exp_vtype = {21'b0, rows[i].instr[30:20]};
            end
            @(posedge clk);
            #2;
        end

        $display("Everything OK");
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready);
        #(rows.size() * ROW_CYCLES * CLK_PERIOD);
        $display("Timeout: the unit did not get through the instruction table in time");
        $display("Something failed");
        $fatal(1);
    end

endmodule

//--- sim.f
source/vec_cfg_pkg.sv
source/vec_types_pkg.sv
source/vec_rf_if.sv
source/vec_csr.sv
source/vec_group_counter.sv
source/vec_sequencer.sv
source/vec_regbank.sv
source/vec_alu.sv
source/vec_unit_top.sv
bench/tb_vec_unit.sv

//--- source/vec_alu.sv
module vec_alu (
    input  logic                         clk,
    input  logic                         reset_n,
    input  vec_types_pkg::vec_op_e       vector_operation_i,
    input  vec_types_pkg::op_cat_e       op_cat_i,
    input  vec_types_pkg::vew_e          vsew_i,
    input  logic [vec_cfg_pkg::XLEN-1:0] scalar_i,
    input  logic [4:0]                   imm_i,
    input  logic                         exec_i,
    vec_rf_if.alu                        rf,
    output logic [vec_cfg_pkg::XLEN-1:0] scalar_result_o
);

    import vec_cfg_pkg::*;
    import vec_types_pkg::*;

    logic [31:0]     imm_ext;
    logic [VLEN-1:0] second_sel;
    vec_op_e         op_q;
    vec_word_u       opa_q;
    vec_word_u       opb_q;
    vec_word_u       result;
    vec_word_u       vs2_word;

    function automatic logic [VLEN-1:0] replicate(input logic [31:0] value, input vew_e sew);
        case (sew)
            EW8:     return {VLENB{value[7:0]}};
            EW16:    return {(VLENB/2){value[15:0]}};
            default: return {(VLENB/4){value}};
        endcase
    endfunction

    // One lane, operands zero-extended to 32 bits
    function automatic logic [31:0] lane_op(input vec_op_e op, input logic [31:0] x,
                                            input logic [31:0] y, input vew_e sew);
        logic [31:0] xs;
        logic [4:0]  sh;
        case (sew)
            EW8: begin
                xs = {{24{x[7]}}, x[7:0]};
                sh = {2'b00, y[2:0]};
            end
            EW16: begin
                xs = {{16{x[15]}}, x[15:0]};
                sh = {1'b0, y[3:0]};
            end
            default: begin
                xs = x;
                sh = y[4:0];
            end
        endcase
        case (op)
            VADD:    return x + y;
            VSUB:    return x - y;
            VAND:    return x & y;
            VOR:     return x | y;
            VXOR:    return x ^ y;
            VSLL:    return x << sh;
            VSRL:    return x >> sh;
            VSRA:    return $signed(xs) >>> sh;
            VMINU:   return (x < y) ? x : y;
            VMAXU:   return (x < y) ? y : x;
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Operand selection and registers
    ////////////////////////////////////////////////////////////////////////////

    // Shift amounts are unsigned
    assign imm_ext = (vector_operation_i inside {VSLL, VSRL, VSRA}) ?
                     {27'b0, imm_i} : {{27{imm_i[4]}}, imm_i};

    always_comb begin
        case (op_cat_i)
            OPIVX:   second_sel = replicate(scalar_i, vsew_i);
            OPIVI:   second_sel = replicate(imm_ext, vsew_i);
            default: second_sel = rf.vs1_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (exec_i) begin
            opa_q <= rf.vs2_data;
            opb_q <= second_sel;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_q <= VNOP;
        end else if (exec_i) begin
            op_q <= vector_operation_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lanes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        result = '0;
        case (vsew_i)
            EW8: begin
                for (int i = 0; i < VLENB; i++) begin
                    result.b[i] = 8'(lane_op(op_q, 32'(opa_q.b[i]), 32'(opb_q.b[i]), vsew_i));
                end
            end
            EW16: begin
                for (int i = 0; i < VLENB/2; i++) begin
                    result.h[i] = 16'(lane_op(op_q, 32'(opa_q.h[i]), 32'(opb_q.h[i]), vsew_i));
                end
            end
            default: begin
                for (int i = 0; i < VLENB/4; i++) begin
                    result.w[i] = lane_op(op_q, opa_q.w[i], opb_q.w[i], vsew_i);
                end
            end
        endcase
    end

    assign rf.wr_data = result;

    // Element 0 of vs2 for vmv.x.s
    assign vs2_word = rf.vs2_data;

    always_comb begin
        case (vsew_i)
            EW8:     scalar_result_o = XLEN'($signed(vs2_word.b[0]));
            EW16:    scalar_result_o = XLEN'($signed(vs2_word.h[0]));
            default: scalar_result_o = XLEN'($signed(vs2_word.w[0]));
        endcase
    end

endmodule

//--- source/vec_cfg_pkg.sv
package vec_cfg_pkg;

    // Vector register geometry
    localparam int VLEN  = 64;
    localparam int VLENB = VLEN / 8;

    // Scalar side
    localparam int XLEN = 32;

    // Register bank size and index width
    localparam int NREGS      = 32;
    localparam int REG_ADDR_W = 5;

endpackage

//--- source/vec_csr.sv
module vec_csr (
    input  logic                          clk,
    input  logic                          reset_n,
    input  vec_types_pkg::vec_op_e        vector_operation_i,
    input  logic [10:0]                   zimm_i,
    input  logic [vec_cfg_pkg::XLEN-1:0]  avl_i,
    input  logic                          rs1_zero_i,
    input  logic                          rd_zero_i,
    output vec_types_pkg::vew_e           vsew_o,
    output vec_types_pkg::vlmul_e         vlmul_o,
    output logic [vec_cfg_pkg::XLEN-1:0]  vl_o,
    output logic [vec_cfg_pkg::XLEN-1:0]  vl_next_o,
    output logic [vec_cfg_pkg::XLEN-1:0]  vtype_o
);

    import vec_cfg_pkg::*;
    import vec_types_pkg::*;

    logic [XLEN-1:0] vl_q;
    logic [XLEN-1:0] vtype_q;
    logic [XLEN-1:0] vlmax;
    vew_e            sew_req;
    vlmul_e          lmul_req;

    // Requested settings from the immediate
    assign sew_req  = vew_e'(zimm_i[5:3]);
    assign lmul_req = vlmul_e'(zimm_i[2:0]);

    // VLMAX = VLENB * LMUL / SEW bytes
    assign vlmax = (XLEN'(VLENB) << lmul_req[1:0]) >> sew_req[1:0];

    always_comb begin
        if (!rs1_zero_i) begin
            vl_next_o = (avl_i < vlmax) ? avl_i : vlmax;
        end else if (!rd_zero_i) begin
            vl_next_o = vlmax;
        end else begin
            vl_next_o = vl_q;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vl_q    <= '0;
            vtype_q <= '0;
        end else if (vector_operation_i == VSETVLI) begin
            vl_q    <= vl_next_o;
            vtype_q <= XLEN'(zimm_i);
        end
    end

    assign vl_o    = vl_q;
    assign vtype_o = vtype_q;
    assign vsew_o  = vew_e'(vtype_q[5:3]);
    assign vlmul_o = vlmul_e'(vtype_q[2:0]);

endmodule

//--- source/vec_group_counter.sv
module vec_group_counter (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  exec_i,
    input  vec_types_pkg::vlmul_e vlmul_i,
    output logic [2:0]            group_idx_o,
    output logic                  last_o
);

    import vec_types_pkg::*;

    logic [2:0] last_idx;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            group_idx_o <= '0;
        end else if (!exec_i) begin
            group_idx_o <= '0;
        end else begin
            group_idx_o <= group_idx_o + 3'd1;
        end
    end

    // Index of the last register in the group
    always_comb begin
        case (vlmul_i)
            LMUL_1:  last_idx = 3'd0;
            LMUL_2:  last_idx = 3'd1;
            LMUL_4:  last_idx = 3'd3;
            default: last_idx = 3'd7;
        endcase
    end

    assign last_o = (group_idx_o == last_idx);

endmodule

//--- source/vec_regbank.sv
module vec_regbank (
    input  logic   clk,
    input  logic   reset_n,
    vec_rf_if.bank rf
);

    import vec_cfg_pkg::*;

    logic [VLEN-1:0] regs [NREGS];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < NREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < VLENB; b++) begin
                if (rf.wr_be[b]) begin
                    regs[rf.wr_addr][b*8 +: 8] <= rf.wr_data[b*8 +: 8];
                end
            end
        end
    end

    // Combinational reads
    assign rf.vs1_data = regs[rf.vs1_addr];
    assign rf.vs2_data = regs[rf.vs2_addr];

endmodule

//--- source/vec_rf_if.sv
interface vec_rf_if;

    import vec_cfg_pkg::*;

    // Read side
    logic [REG_ADDR_W-1:0] vs1_addr;
    logic [REG_ADDR_W-1:0] vs2_addr;
    logic [VLEN-1:0]       vs1_data;
    logic [VLEN-1:0]       vs2_data;

    // Write side, one enable per byte
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [VLENB-1:0]      wr_be;
    logic [VLEN-1:0]       wr_data;

    modport seq (
        output vs1_addr, vs2_addr, wr_addr, wr_be
    );

    modport bank (
        input  vs1_addr, vs2_addr, wr_addr, wr_be, wr_data,
        output vs1_data, vs2_data
    );

    modport alu (
        input  vs1_data, vs2_data,
        output wr_data
    );

endinterface

//--- source/vec_sequencer.sv
module vec_sequencer (
    input  logic                               clk,
    input  logic                               reset_n,
    input  vec_types_pkg::vec_op_e             vector_operation_i,
    input  logic [vec_cfg_pkg::REG_ADDR_W-1:0] vd_i,
    input  logic [vec_cfg_pkg::REG_ADDR_W-1:0] vs1_i,
    input  logic [vec_cfg_pkg::REG_ADDR_W-1:0] vs2_i,
    input  vec_types_pkg::vew_e                vsew_i,
    input  logic [vec_cfg_pkg::XLEN-1:0]       vl_i,
    input  logic [2:0]                         group_idx_i,
    input  logic                               last_i,
    vec_rf_if.seq                              rf,
    output logic                               exec_o,
    output logic                               hold_o
);

    import vec_cfg_pkg::*;
    import vec_types_pkg::*;

    vec_state_e       state;
    vec_state_e       next_state;
    logic [VLENB-1:0] be_now;
    logic [XLEN-1:0]  elem;

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            V_IDLE: begin
                if (vector_operation_i inside {VNOP, VSETVLI, VMV_X_S}) begin
                    next_state = V_IDLE;
                end else begin
                    next_state = V_EXEC;
                end
            end
            V_EXEC:  next_state = last_i ? V_END : V_EXEC;
            default: next_state = V_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= V_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign exec_o = (state == V_EXEC);
    assign hold_o = (next_state == V_EXEC) || (next_state == V_END);

    ////////////////////////////////////////////////////////////////////////////
    // Register addressing
    ////////////////////////////////////////////////////////////////////////////

    assign rf.vs1_addr = vs1_i + REG_ADDR_W'(group_idx_i);
    assign rf.vs2_addr = vs2_i + REG_ADDR_W'(group_idx_i);

    // Tail bytes past vl stay off
    always_comb begin
        be_now = '0;
        elem   = '0;
        for (int b = 0; b < VLENB; b++) begin
            elem = XLEN'(group_idx_i) * (XLEN'(VLENB) >> vsew_i[1:0])
                 + (XLEN'(b) >> vsew_i[1:0]);
            be_now[b] = exec_o && (elem < vl_i);
        end
    end

    // Write trails the read by one cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rf.wr_be <= '0;
        end else begin
            rf.wr_be <= be_now;
        end
    end

    always_ff @(posedge clk) begin
        rf.wr_addr <= vd_i + REG_ADDR_W'(group_idx_i);
    end

endmodule

//--- source/vec_types_pkg.sv
package vec_types_pkg;

    import vec_cfg_pkg::*;

    // Decoded vector operation, one per instruction
    typedef enum logic [3:0] {
        VNOP,
        VSETVLI,
        VMV_X_S,
        VADD,
        VSUB,
        VAND,
        VOR,
        VXOR,
        VSLL,
        VSRL,
        VSRA,
        VMINU,
        VMAXU
    } vec_op_e;

    // Field encodings as they appear in vtype
    typedef enum logic [2:0] {
        EW8  = 3'b000,
        EW16 = 3'b001,
        EW32 = 3'b010
    } vew_e;

    typedef enum logic [2:0] {
        LMUL_1 = 3'b000,
        LMUL_2 = 3'b001,
        LMUL_4 = 3'b010,
        LMUL_8 = 3'b011
    } vlmul_e;

    // Operand category from funct3
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100
    } op_cat_e;

    typedef enum logic [1:0] {
        V_IDLE,
        V_EXEC,
        V_END
    } vec_state_e;

    // One register word seen as bytes, halfwords or words
    typedef union packed {
        logic [VLENB-1:0][7:0]    b;
        logic [VLENB/2-1:0][15:0] h;
        logic [VLENB/4-1:0][31:0] w;
    } vec_word_u;

endpackage

//--- source/vec_unit_top.sv
module vec_unit_top (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic [31:0]                  instruction_i,
    input  vec_types_pkg::vec_op_e       vector_operation_i,
    input  logic [vec_cfg_pkg::XLEN-1:0] op1_scalar_i,
    output logic                         hold_o,
    output logic [vec_cfg_pkg::XLEN-1:0] vtype_o,
    output logic [vec_cfg_pkg::XLEN-1:0] res_scalar_o,
    output logic                         wr_en_scalar_o
);

    import vec_cfg_pkg::*;
    import vec_types_pkg::*;

    // Instruction fields
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [2:0]            funct3;
    logic [10:0]           zimm;
    op_cat_e               op_cat;

    vew_e            vsew;
    vlmul_e          vlmul;
    logic [XLEN-1:0] vl;
    logic [XLEN-1:0] vl_next;
    logic [2:0]      group_idx;
    logic            last;
    logic            exec;
    logic [XLEN-1:0] alu_scalar;

    assign rd     = instruction_i[11:7];
    assign funct3 = instruction_i[14:12];
    assign rs1    = instruction_i[19:15];
    assign rs2    = instruction_i[24:20];
    assign zimm   = instruction_i[30:20];
    assign op_cat = op_cat_e'(funct3);

    vec_rf_if rf ();

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////

    vec_csr u_csr (
        .clk                (clk),
        .reset_n            (reset_n),
        .vector_operation_i (vector_operation_i),
        .zimm_i             (zimm),
        .avl_i              (op1_scalar_i),
        .rs1_zero_i         (rs1 == '0),
        .rd_zero_i          (rd == '0),
        .vsew_o             (vsew),
        .vlmul_o            (vlmul),
        .vl_o               (vl),
        .vl_next_o          (vl_next),
        .vtype_o            (vtype_o)
    );

    vec_group_counter u_counter (
        .clk         (clk),
        .reset_n     (reset_n),
        .exec_i      (exec),
        .vlmul_i     (vlmul),
        .group_idx_o (group_idx),
        .last_o      (last)
    );

    vec_sequencer u_seq (
        .clk                (clk),
        .reset_n            (reset_n),
        .vector_operation_i (vector_operation_i),
        .vd_i               (rd),
        .vs1_i              (rs1),
        .vs2_i              (rs2),
        .vsew_i             (vsew),
        .vl_i               (vl),
        .group_idx_i        (group_idx),
        .last_i             (last),
        .rf                 (rf),
        .exec_o             (exec),
        .hold_o             (hold_o)
    );

    vec_regbank u_bank (
        .clk     (clk),
        .reset_n (reset_n),
        .rf      (rf)
    );

    vec_alu u_alu (
        .clk                (clk),
        .reset_n            (reset_n),
        .vector_operation_i (vector_operation_i),
        .op_cat_i           (op_cat),
        .vsew_i             (vsew),
        .scalar_i           (op1_scalar_i),
        .imm_i              (rs1),
        .exec_i             (exec),
        .rf                 (rf),
        .scalar_result_o    (alu_scalar)
    );

    // Scalar write-back
    always_comb begin
        case (vector_operation_i)
            VSETVLI: begin
                res_scalar_o   = vl_next;
                wr_en_scalar_o = 1'b1;
            end
            VMV_X_S: begin
                res_scalar_o   = alu_scalar;
                wr_en_scalar_o = 1'b1;
            end
            default: begin
                res_scalar_o   = '0;
                wr_en_scalar_o = 1'b0;
            end
        endcase
    end

endmodule
